/* src/zmem_pkg.sv */
package zmem_pkg;

	// widths of the cpu side
	localparam int CPU_AW = 16;
	localparam int BYTE_W = 8;

	// widths of the dram side
	localparam int PAGE_W = 8;
	localparam int DRAM_AW = 21;
	localparam int WORD_W = 16;

	// cache split of a dram word address
	localparam int INDEX_W = 8;
	localparam int TAG_W = DRAM_AW - INDEX_W;

	typedef logic [CPU_AW-1:0] cpu_addr_t;
	typedef logic [PAGE_W-1:0] page_t;
	// page on top of za[13:1]
	typedef logic [DRAM_AW-1:0] dram_addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;

	// rom lives in the top 32 pages
	localparam page_t ROM_PAGE_BASE = 8'hE0;
	// za[13:8] of the dos entry point, 3Dxx
	localparam logic [5:0] DOS_ENTRY_HI = 6'h3D;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		DRAM_REQ,
		DRAM_REL,
		WAIT,
		DONE
	} ctrl_state_t;

endpackage

/* src/mem_pager.sv */
`timescale 1ns/1ns

module mem_pager (
	input  logic                 clk,
	input  logic                 rst,
	input  zmem_pkg::cpu_addr_t  za,
	input  logic                 z_opfetch,
	input  logic                 access_start,
	input  logic [31:0]          page_regs,
	input  logic [3:0]           memconf,
	output zmem_pkg::dram_addr_t dram_addr,
	output logic                 rom_sel,
	output logic                 wr_allow,
	output logic                 dos
);

	logic [1:0] win;
	logic win0;
	zmem_pkg::page_t win_page;
	zmem_pkg::page_t rom_page;
	zmem_pkg::page_t page;
	logic [4:0] rom_pg;
	logic dos_r;
	logic dos_on;
	logic dos_off;
	logic dos_flip;

	// window from the two top address bits
	assign win = za[15:14];
	assign win0 = (win == 2'b00);

	// one byte of page_regs per window
	assign win_page = page_regs[8*win +: 8];

	// window 0 holds rom unless memconf[3] maps ram there
	assign rom_sel = win0 && !memconf[3];

	// low two rom page bits follow dos and the trap enable
	// memconf[2] hands them back to the page register
	assign rom_pg = {page_regs[4:2], memconf[2] ? page_regs[1:0] : {~dos, memconf[0]}};
	assign rom_page = zmem_pkg::ROM_PAGE_BASE | {3'b000, rom_pg};

	assign page = rom_sel ? rom_page : win_page;

	// word address, za[0] picks the byte later
	assign dram_addr = {page, za[13:1]};

	// only the rom window can be write protected
	assign wr_allow = !rom_sel || memconf[1];

	// dos trap, sampled once per access at its start
	assign dos_on = win0 && z_opfetch && access_start
		&& (za[13:8] == zmem_pkg::DOS_ENTRY_HI)
		&& memconf[0] && !memconf[2];
	// any opcode fetch outside window 0 leaves dos
	assign dos_off = !win0 && z_opfetch && access_start;

	// pending change of the flag
	assign dos_flip = (dos_on && !dos_r) || (dos_off && dos_r);

	// new value visible one clock before dos_r
	assign dos = dos_r ^ dos_flip;

	always_ff @(posedge clk)
	begin
		if (rst)
			dos_r <= 1'b0;
		else if (dos_off)
			dos_r <= 1'b0;
		else if (dos_on)
			dos_r <= 1'b1;
	end

endmodule

/* src/line_cache.sv */
`timescale 1ns/1ns

module line_cache #(
	parameter int CACHE_LINES = 256
) (
	input  logic                 clk,
	input  logic                 rst,
	input  zmem_pkg::dram_addr_t lookup_addr,
	output logic                 hit,
	output zmem_pkg::word_t      hit_data,
	input  logic                 fill,
	input  zmem_pkg::word_t      fill_data,
	input  logic                 inval
);

	// slot bits, up to the full 8-bit index
	localparam int IW = $clog2(CACHE_LINES);

	zmem_pkg::tag_t addr_tag;
	zmem_pkg::index_t addr_idx;
	logic [IW-1:0] slot;

	logic [CACHE_LINES-1:0] valid;
	zmem_pkg::tag_t tag_mem [CACHE_LINES];
	// index bits above the slot, only matter below 256 lines
	zmem_pkg::index_t idx_mem [CACHE_LINES];
	zmem_pkg::word_t data_mem [CACHE_LINES];

	assign addr_tag = lookup_addr[20:8];
	assign addr_idx = lookup_addr[7:0];
	assign slot = addr_idx[IW-1:0];

	// direct mapped, one compare
	assign hit = valid[slot]
		&& (tag_mem[slot] == addr_tag)
		&& (idx_mem[slot] == addr_idx);
	assign hit_data = data_mem[slot];

	// per-line valid bits
	always_ff @(posedge clk)
	begin
		if (rst)
			valid <= '0;
		else if (fill)
			valid[slot] <= 1'b1;
		// drop the line only if this address owns it
		else if (inval && hit)
			valid[slot] <= 1'b0;
	end

	// line contents
	always_ff @(posedge clk)
	begin
		if (fill)
		begin
			tag_mem[slot] <= addr_tag;
			idx_mem[slot] <= addr_idx;
			data_mem[slot] <= fill_data;
		end
	end

	// reads fill, writes invalidate, never in one cycle
	a_fill_inval_excl: assert property (
		@(posedge clk) disable iff (rst)
		!(fill && inval)
	);

endmodule

/* src/wait_timer.sv */
`timescale 1ns/1ns

module wait_timer #(
	parameter int WAIT_CYCLES = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic turbo,
	output logic expired
);

	localparam int CW = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

	logic [CW-1:0] cnt;
	logic [CW-1:0] cnt_next;

	always_comb
	begin
		if (load)
			// turbo skips the slow wait entirely
			cnt_next = turbo ? '0 : CW'(WAIT_CYCLES);
		else if (cnt != '0)
			cnt_next = cnt - 1'b1;
		else
			cnt_next = '0;
	end

	// count about to land on zero
	assign expired = (cnt_next == '0);

	always_ff @(posedge clk)
	begin
		if (rst)
			cnt <= '0;
		else
			cnt <= cnt_next;
	end

endmodule

/* src/access_ctrl.sv */
`timescale 1ns/1ns

module access_ctrl #(
	parameter int WAIT_CYCLES = 2
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            z_req,
	input  logic            z_rd,
	input  logic            z_wr,
	input  logic            za0,
	input  zmem_pkg::byte_t z_wdata,
	input  logic            rom_sel,
	input  logic            wr_allow,
	input  logic            cache_en,
	input  logic            hit,
	input  zmem_pkg::word_t hit_data,
	output logic            access_start,
	output logic            fill,
	output logic            inval,
	output logic            timer_load,
	input  logic            timer_expired,
	output logic            dram_req,
	output logic            dram_we,
	output logic            dram_bsel,
	output zmem_pkg::word_t dram_wdata,
	input  logic            dram_ack,
	input  zmem_pkg::word_t dram_rdata,
	output logic            z_done,
	output zmem_pkg::byte_t z_rdata
);

	zmem_pkg::ctrl_state_t state;
	zmem_pkg::ctrl_state_t state_n;
	zmem_pkg::word_t rdata_r;
	logic cache_hit;
	logic wr_blocked;

	// rom reads are cached like ram
	assign cache_hit = z_rd && cache_en && hit;
	// protected rom write, finishes with no dram cycle
	assign wr_blocked = z_wr && rom_sel && !wr_allow;

	always_comb
	begin
		state_n = state;
		access_start = 1'b0;
		timer_load = 1'b0;
		fill = 1'b0;
		inval = 1'b0;
		case (state)
			zmem_pkg::IDLE:
			begin
				if (z_req)
				begin
					access_start = 1'b1;
					state_n = zmem_pkg::LOOKUP;
				end
			end
			zmem_pkg::LOOKUP:
			begin
				if (cache_hit || wr_blocked)
				begin
					// turbo load expires at once, straight to DONE
					timer_load = 1'b1;
					state_n = timer_expired ? zmem_pkg::DONE : zmem_pkg::WAIT;
				end
				else
				begin
					// stale copy goes before the write lands
					inval = z_wr;
					state_n = zmem_pkg::DRAM_REQ;
				end
			end
			zmem_pkg::DRAM_REQ:
			begin
				if (dram_ack)
				begin
					fill = !dram_we;
					state_n = zmem_pkg::DRAM_REL;
				end
			end
			zmem_pkg::DRAM_REL:
			begin
				// four-phase, wait for ack to drop
				if (!dram_ack)
				begin
					timer_load = 1'b1;
					state_n = timer_expired ? zmem_pkg::DONE : zmem_pkg::WAIT;
				end
			end
			zmem_pkg::WAIT:
			begin
				if (timer_expired)
					state_n = zmem_pkg::DONE;
			end
			zmem_pkg::DONE:
			begin
				// hold until the cpu ends its cycle
				if (!z_req)
					state_n = zmem_pkg::IDLE;
			end
			default:
				state_n = zmem_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= zmem_pkg::IDLE;
			dram_req <= 1'b0;
			z_done <= 1'b0;
		end
		else
		begin
			state <= state_n;
			// pulse on entry to DONE only
			z_done <= (state_n == zmem_pkg::DONE) && (state != zmem_pkg::DONE);
			if (state_n == zmem_pkg::DRAM_REQ && state == zmem_pkg::LOOKUP)
				dram_req <= 1'b1;
			else if (state == zmem_pkg::DRAM_REQ && dram_ack)
				dram_req <= 1'b0;
		end
	end

	// request payload, frozen while dram_req is up
	always_ff @(posedge clk)
	begin
		if (state == zmem_pkg::LOOKUP)
		begin
			dram_we <= z_wr;
			dram_bsel <= za0;
			dram_wdata <= {z_wdata, z_wdata};
			if (cache_hit)
				rdata_r <= hit_data;
		end
		else if (fill)
			rdata_r <= dram_rdata;
	end

	// byte lane by za0
	assign z_rdata = za0 ? rdata_r[15:8] : rdata_r[7:0];

	a_req_held: assert property (
		@(posedge clk) disable iff (rst)
		(state == zmem_pkg::DRAM_REQ && !dram_ack) |=> dram_req
	);

	a_done_pulse: assert property (
		@(posedge clk) disable iff (rst)
		z_done |=> !z_done
	);

endmodule

/* src/zmem_top.sv */
`timescale 1ns/1ns

module zmem_top #(
	parameter int WAIT_CYCLES = 2,
	parameter int CACHE_LINES = 256
) (
	input  logic                 clk,
	input  logic                 rst,
	// cpu side
	input  logic                 z_req,
	input  logic                 z_rd,
	input  logic                 z_wr,
	input  logic                 z_opfetch,
	input  zmem_pkg::cpu_addr_t  za,
	input  zmem_pkg::byte_t      z_wdata,
	output logic                 z_done,
	output zmem_pkg::byte_t      z_rdata,
	// configuration
	input  logic                 turbo,
	input  logic                 cache_en,
	input  logic [3:0]           memconf,
	input  logic [31:0]          page_regs,
	output logic                 dos,
	// dram side
	output logic                 dram_req,
	input  logic                 dram_ack,
	output zmem_pkg::dram_addr_t dram_addr,
	output logic                 dram_we,
	output logic                 dram_bsel,
	output zmem_pkg::word_t      dram_wdata,
	input  zmem_pkg::word_t      dram_rdata
);

	logic access_start;
	logic rom_sel;
	logic wr_allow;
	logic hit;
	zmem_pkg::word_t hit_data;
	logic fill;
	logic inval;
	logic timer_load;
	logic timer_expired;

	// address path and dos flag
	mem_pager u_pager (
		.clk          (clk),
		.rst          (rst),
		.za           (za),
		.z_opfetch    (z_opfetch),
		.access_start (access_start),
		.page_regs    (page_regs),
		.memconf      (memconf),
		.dram_addr    (dram_addr),
		.rom_sel      (rom_sel),
		.wr_allow     (wr_allow),
		.dos          (dos)
	);

	// cache looks up the same address the dram sees
	line_cache #(
		.CACHE_LINES (CACHE_LINES)
	) u_cache (
		.clk         (clk),
		.rst         (rst),
		.lookup_addr (dram_addr),
		.hit         (hit),
		.hit_data    (hit_data),
		.fill        (fill),
		.fill_data   (dram_rdata),
		.inval       (inval)
	);

	wait_timer #(
		.WAIT_CYCLES (WAIT_CYCLES)
	) u_timer (
		.clk     (clk),
		.rst     (rst),
		.load    (timer_load),
		.turbo   (turbo),
		.expired (timer_expired)
	);

	access_ctrl #(
		.WAIT_CYCLES (WAIT_CYCLES)
	) u_ctrl (
		.clk           (clk),
		.rst           (rst),
		.z_req         (z_req),
		.z_rd          (z_rd),
		.z_wr          (z_wr),
		.za0           (za[0]),
		.z_wdata       (z_wdata),
		.rom_sel       (rom_sel),
		.wr_allow      (wr_allow),
		.cache_en      (cache_en),
		.hit           (hit),
		.hit_data      (hit_data),
		.access_start  (access_start),
		.fill          (fill),
		.inval         (inval),
		.timer_load    (timer_load),
		.timer_expired (timer_expired),
		.dram_req      (dram_req),
		.dram_we       (dram_we),
		.dram_bsel     (dram_bsel),
		.dram_wdata    (dram_wdata),
		.dram_ack      (dram_ack),
		.dram_rdata    (dram_rdata),
		.z_done        (z_done),
		.z_rdata       (z_rdata)
	);

endmodule

/* dv/zmem_tb.sv */
`timescale 1ns/1ns

module zmem_tb;

	localparam int WAIT_CYCLES = 2;
	localparam int CACHE_LINES = 256;
	// all tests together need a few hundred cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic clk;
	logic rst;
	logic z_req;
	logic z_rd;
	logic z_wr;
	logic z_opfetch;
	zmem_pkg::cpu_addr_t za;
	zmem_pkg::byte_t z_wdata;
	logic z_done;
	zmem_pkg::byte_t z_rdata;
	logic turbo;
	logic cache_en;
	logic [3:0] memconf;
	logic [31:0] page_regs;
	logic dos;
	logic dram_req;
	logic dram_ack;
	zmem_pkg::dram_addr_t dram_addr;
	logic dram_we;
	logic dram_bsel;
	zmem_pkg::word_t dram_wdata;
	zmem_pkg::word_t dram_rdata;

	// dram model state
	zmem_pkg::word_t mem [0:(1<<21)-1];
	logic [31:0] rng;
	int ack_wait;
	int req_count;
	logic req_prev;
	int cycle_count;

	zmem_top #(
		.WAIT_CYCLES (WAIT_CYCLES),
		.CACHE_LINES (CACHE_LINES)
	) i_dut (
		.clk        (clk),
		.rst        (rst),
		.z_req      (z_req),
		.z_rd       (z_rd),
		.z_wr       (z_wr),
		.z_opfetch  (z_opfetch),
		.za         (za),
		.z_wdata    (z_wdata),
		.z_done     (z_done),
		.z_rdata    (z_rdata),
		.turbo      (turbo),
		.cache_en   (cache_en),
		.memconf    (memconf),
		.page_regs  (page_regs),
		.dos        (dos),
		.dram_req   (dram_req),
		.dram_ack   (dram_ack),
		.dram_addr  (dram_addr),
		.dram_we    (dram_we),
		.dram_bsel  (dram_bsel),
		.dram_wdata (dram_wdata),
		.dram_rdata (dram_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// every address bit shows up in the word
	function automatic zmem_pkg::word_t pattern_word(input logic [20:0] a);
		return a[15:0] ^ {3'b000, a[20:8]};
	endfunction

	// byte the cpu should see at a in page pg
	function automatic zmem_pkg::byte_t mem_byte(input zmem_pkg::cpu_addr_t a,
		input zmem_pkg::page_t pg);
		zmem_pkg::word_t w;
		w = mem[{pg, a[13:1]}];
		return a[0] ? w[15:8] : w[7:0];
	endfunction

	// rom page from window 0 register, dos and memconf
	function automatic zmem_pkg::page_t rom_page_of(input logic dos_now, input logic [3:0] mc);
		logic [1:0] low;
		low = mc[2] ? page_regs[1:0] : {~dos_now, mc[0]};
		return zmem_pkg::ROM_PAGE_BASE | {3'b000, page_regs[4:2], low};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	// one cpu bus cycle, returns read byte and cycles up to z_done
	task automatic cpu_access(input zmem_pkg::cpu_addr_t a, input logic wr, input logic opf,
		input zmem_pkg::byte_t wd, output zmem_pkg::byte_t rd, output int cycles);
		@(negedge clk);
		za = a;
		z_rd = !wr;
		z_wr = wr;
		z_opfetch = opf;
		z_wdata = wd;
		z_req = 1'b1;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end while (z_done !== 1'b1);
		rd = z_rdata;
		z_req = 1'b0;
		z_rd = 1'b0;
		z_wr = 1'b0;
		z_opfetch = 1'b0;
	endtask

	// dram responder, four-phase with random ack delay
	initial
	begin
		dram_ack = 1'b0;
		dram_rdata = '0;
		ack_wait = 0;
		req_count = 0;
		req_prev = 1'b0;
		rng = 32'h6d815aec;
		for (int a = 0; a < (1 << 21); a++)
			mem[a] = pattern_word(a[20:0]);
		forever
		begin
			@(negedge clk);
			if (dram_req === 1'b1 && !req_prev)
				req_count++;
			req_prev = (dram_req === 1'b1);
			if (dram_ack)
			begin
				// release once the request is gone
				if (!dram_req)
					dram_ack = 1'b0;
			end
			else if (dram_req === 1'b1)
			begin
				if (ack_wait == 0)
				begin
					rng = xorshift32(rng);
					ack_wait = 1 + int'(rng % 4);
				end
				ack_wait--;
				if (ack_wait == 0)
				begin
					if (dram_we && dram_bsel)
						mem[dram_addr][15:8] = dram_wdata[15:8];
					else if (dram_we)
						mem[dram_addr][7:0] = dram_wdata[7:0];
					else
						dram_rdata = mem[dram_addr];
					dram_ack = 1'b1;
				end
			end
		end
	end

	initial
	begin
		cycle_count = 0;
		forever
		begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= TIMEOUT_CYCLES)
				abort_run($sformatf("timeout, run still going after %0d cycles", cycle_count));
		end
	end

	task automatic paging_roundtrip();
		zmem_pkg::cpu_addr_t addrs [4];
		zmem_pkg::page_t pages [4];
		zmem_pkg::byte_t wb [4];
		zmem_pkg::byte_t got;
		int cyc;
		addrs = '{16'h0123, 16'h4567, 16'h8A9B, 16'hC0DE};
		pages = '{8'h05, 8'h13, 8'h2A, 8'h47};
		wb = '{8'hA1, 8'hB2, 8'hC3, 8'hD4};
		// window 0 as ram
		memconf = 4'b1000;
		page_regs = {pages[3], pages[2], pages[1], pages[0]};
		for (int i = 0; i < 4; i++)
		begin
			cpu_access(addrs[i], 1'b1, 1'b0, wb[i], got, cyc);
			expect_eq("dram byte", mem_byte(addrs[i], pages[i]), wb[i]);
		end
		for (int i = 0; i < 4; i++)
		begin
			cpu_access(addrs[i], 1'b0, 1'b0, 8'h00, got, cyc);
			expect_eq("z_rdata", got, wb[i]);
		end
	endtask

	task automatic cache_hit_latency();
		zmem_pkg::byte_t first;
		zmem_pkg::byte_t second;
		int cyc;
		int reqs;
		memconf = 4'b1000;
		turbo = 1'b1;
		cpu_access(16'h5310, 1'b0, 1'b0, 8'h00, first, cyc);
		expect_eq("z_rdata", first, mem_byte(16'h5310, 8'h13));
		reqs = req_count;
		cpu_access(16'h5310, 1'b0, 1'b0, 8'h00, second, cyc);
		expect_eq("dram_req rises", req_count, reqs);
		// IDLE, LOOKUP, DONE
		expect_eq("z_done latency", cyc, 2);
		expect_eq("z_rdata", second, first);
	endtask

	task automatic slow_mode_delay();
		zmem_pkg::byte_t got;
		int cyc;
		int reqs;
		// line still cached from the hit test
		turbo = 1'b0;
		reqs = req_count;
		cpu_access(16'h5310, 1'b0, 1'b0, 8'h00, got, cyc);
		expect_eq("dram_req rises", req_count, reqs);
		expect_eq("z_done latency", cyc, 2 + WAIT_CYCLES);
		expect_eq("z_rdata", got, mem_byte(16'h5310, 8'h13));
		turbo = 1'b1;
	endtask

	task automatic write_invalidates();
		zmem_pkg::byte_t old;
		zmem_pkg::byte_t flipped;
		zmem_pkg::byte_t got;
		int cyc;
		int reqs;
		memconf = 4'b1000;
		cpu_access(16'h9230, 1'b0, 1'b0, 8'h00, old, cyc);
		flipped = ~old;
		reqs = req_count;
		cpu_access(16'h9230, 1'b1, 1'b0, flipped, got, cyc);
		expect_eq("dram_req rises", req_count, reqs + 1);
		cpu_access(16'h9230, 1'b0, 1'b0, 8'h00, got, cyc);
		expect_eq("dram_req rises", req_count, reqs + 2);
		expect_eq("z_rdata", got, flipped);
	endtask

	task automatic rom_protect();
		zmem_pkg::page_t pg;
		zmem_pkg::byte_t old;
		zmem_pkg::byte_t flipped;
		zmem_pkg::byte_t got;
		int cyc;
		int reqs;
		memconf = 4'b0000;
		pg = rom_page_of(1'b0, memconf);
		cpu_access(16'h1234, 1'b0, 1'b0, 8'h00, old, cyc);
		expect_eq("z_rdata", old, mem_byte(16'h1234, pg));
		flipped = ~old;
		// protected write ends like a hit
		reqs = req_count;
		cpu_access(16'h1234, 1'b1, 1'b0, flipped, got, cyc);
		expect_eq("dram_req rises", req_count, reqs);
		expect_eq("z_done latency", cyc, 2);
		expect_eq("rom byte", mem_byte(16'h1234, pg), old);
		memconf = 4'b0010;
		cpu_access(16'h1234, 1'b1, 1'b0, flipped, got, cyc);
		expect_eq("dram_req rises", req_count, reqs + 1);
		expect_eq("rom byte", mem_byte(16'h1234, pg), flipped);
		cpu_access(16'h1234, 1'b0, 1'b0, 8'h00, got, cyc);
		expect_eq("z_rdata", got, flipped);
	endtask

	task automatic dos_trap();
		zmem_pkg::byte_t got;
		int cyc;
		memconf = 4'b0001;
		cpu_access(16'h3D00, 1'b0, 1'b0, 8'h00, got, cyc);
		expect_eq("dos", dos, 1'b0);
		expect_eq("z_rdata", got, mem_byte(16'h3D00, rom_page_of(1'b0, memconf)));
		// entry fetch already sees the dos rom page
		cpu_access(16'h3D00, 1'b0, 1'b1, 8'h00, got, cyc);
		expect_eq("dos", dos, 1'b1);
		expect_eq("z_rdata", got, mem_byte(16'h3D00, rom_page_of(1'b1, memconf)));
		cpu_access(16'h4100, 1'b0, 1'b1, 8'h00, got, cyc);
		expect_eq("dos", dos, 1'b0);
		cpu_access(16'h3D00, 1'b0, 1'b0, 8'h00, got, cyc);
		expect_eq("z_rdata", got, mem_byte(16'h3D00, rom_page_of(1'b0, memconf)));
	endtask

	initial
	begin
		rst = 1'b1;
		z_req = 1'b0;
		z_rd = 1'b0;
		z_wr = 1'b0;
		z_opfetch = 1'b0;
		za = '0;
		z_wdata = '0;
		turbo = 1'b1;
		cache_en = 1'b1;
		memconf = 4'b1000;
		page_regs = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		paging_roundtrip();
		cache_hit_latency();
		slow_mode_delay();
		write_invalidates();
		rom_protect();
		dos_trap();
		$display("TEST PASS");
		$finish;
	end

endmodule

/* list.f */
src/zmem_pkg.sv
src/mem_pager.sv
src/line_cache.sv
src/wait_timer.sv
src/access_ctrl.sv
src/zmem_top.sv
dv/zmem_tb.sv

/* Bender.yml */
package:
  name: zmem

sources:
  - src/zmem_pkg.sv
  - src/mem_pager.sv
  - src/line_cache.sv
  - src/wait_timer.sv
  - src/access_ctrl.sv
  - src/zmem_top.sv
  - target: test
    files:
      - dv/zmem_tb.sv
